// ==== Makefile ====
# Verilator build, run and lint of the vcache subarray

VERILATOR  ?= verilator
TOP        ?= tb_vcache_subarray
RTL_TOP    ?= vcache_subarray_top
FILELIST   ?= filelist.f
OBJ_DIR    ?= obj_dir
TIMESCALE  ?= 1ns/1ps
VFLAGS     ?= --binary --timing --assert --timescale $(TIMESCALE)
LINT_FLAGS ?= --lint-only --timing -Wall --timescale $(TIMESCALE)
PASS_MSG   ?= Result: PASSED

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)

run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP) 2>&1)"; echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST) --top-module $(RTL_TOP)

clean:
	rm -rf $(OBJ_DIR)

// ==== filelist.f ====
+incdir+include
source/vcache_pkg.sv
source/credit_fifo.sv
source/vcache_tile.sv
source/vcache_array.sv
source/vcache_subarray_top.sv
tests/tb_clock_gen.sv
tests/tb_vcache_subarray.sv

// ==== include/vcache_macros.svh ====
// sizing macros for the vcache subarray
// columns, lines per tile, word widths and link FIFO depth

`ifndef VCACHE_MACROS_SVH
`define VCACHE_MACROS_SVH

// tiles in the row and bits to name one
`define NUM_COLS 4
`define COL_W 2

// direct-mapped, one word per line
`define SETS 8

`define ADDR_W 12
`define DATA_W 32

// receiver FIFO depth, also the sender's initial credit count
`define FIFO_DEPTH 2

`endif

// ==== source/credit_fifo.sv ====
// credit_fifo: link receiver buffer
// circular buffer, one credit pulse back per pop

`timescale 1ns/1ps
`include "vcache_macros.svh"

module credit_fifo #(
  parameter type payload_t  = logic,
  parameter int  FIFO_DEPTH = `FIFO_DEPTH
) (
  input  logic     clk_i,
  input  logic     arst_n_i,
  input  logic     valid_i,
  input  payload_t data_i,
  output logic     valid_o,
  output payload_t data_o,
  input  logic     pop_i,
  output logic     credit_o
);

  localparam int ptr_width_lp = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
  localparam int cnt_width_lp = $clog2(FIFO_DEPTH + 1);

  payload_t                mem_q [FIFO_DEPTH];
  logic [ptr_width_lp-1:0] wr_ptr_q;
  logic [ptr_width_lp-1:0] rd_ptr_q;
  logic [cnt_width_lp-1:0] count_q;
  logic                    pop;

  function automatic logic [ptr_width_lp-1:0] ptr_inc(input logic [ptr_width_lp-1:0] ptr);
    if (ptr == ptr_width_lp'(FIFO_DEPTH - 1)) begin
      ptr_inc = '0;
    end else begin
      ptr_inc = ptr + 1'b1;
    end
  endfunction

  assign valid_o = (count_q != '0);
  assign data_o  = mem_q[rd_ptr_q];
  assign pop     = pop_i && valid_o;

  // sender credits keep a push off a full buffer
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
      credit_o <= 1'b0;
    end else begin
      if (valid_i) begin
        wr_ptr_q <= ptr_inc(wr_ptr_q);
      end
      if (pop) begin
        rd_ptr_q <= ptr_inc(rd_ptr_q);
      end
      count_q  <= count_q + cnt_width_lp'(valid_i) - cnt_width_lp'(pop);
      credit_o <= pop;
    end
  end

  always_ff @(posedge clk_i) begin
    if (valid_i) begin
      mem_q[wr_ptr_q] <= data_i;
    end
  end

endmodule

// ==== source/vcache_array.sv ====
// vcache_array: one row of vcache tiles
// west request chain and east fill chain between neighbours

`timescale 1ns/1ps
`include "vcache_macros.svh"

module vcache_array (
  input  logic                                 clk_i,
  input  logic                                 arst_n_i,

  input  logic [`NUM_COLS-1:0]                 core_req_valid_i,
  input  vcache_pkg::core_req_s [`NUM_COLS-1:0] core_req_i,
  output logic [`NUM_COLS-1:0]                 core_req_credit_o,
  output logic [`NUM_COLS-1:0]                 core_rsp_valid_o,
  output vcache_pkg::core_rsp_s [`NUM_COLS-1:0] core_rsp_o,
  input  logic [`NUM_COLS-1:0]                 core_rsp_credit_i,

  output logic                                 mem_req_valid_o,
  output vcache_pkg::mem_pkt_s                 mem_req_o,
  input  logic                                 mem_req_credit_i,
  input  logic                                 mem_fill_valid_i,
  input  vcache_pkg::mem_pkt_s                 mem_fill_i,
  output logic                                 mem_fill_credit_o
);

  import vcache_pkg::*;

  // west-going request links, indexed by tile
  wire [`NUM_COLS-1:0]           west_pkt_valid_lo;
  wire mem_pkt_s [`NUM_COLS-1:0] west_pkt_lo;
  wire [`NUM_COLS-1:0]           west_pkt_credit_li;
  wire [`NUM_COLS-1:0]           east_pkt_valid_li;
  wire mem_pkt_s [`NUM_COLS-1:0] east_pkt_li;
  wire [`NUM_COLS-1:0]           east_pkt_credit_lo;

  // east-going fill links
  wire [`NUM_COLS-1:0]           west_fill_valid_li;
  wire mem_pkt_s [`NUM_COLS-1:0] west_fill_li;
  wire [`NUM_COLS-1:0]           west_fill_credit_lo;
  wire [`NUM_COLS-1:0]           east_fill_valid_lo;
  wire mem_pkt_s [`NUM_COLS-1:0] east_fill_lo;
  wire [`NUM_COLS-1:0]           east_fill_credit_li;

  for (genvar c = 0; c < `NUM_COLS; c++) begin : tile

    vcache_tile #(
      .COL(c)
    ) vc (
      .clk_i(clk_i),
      .arst_n_i(arst_n_i),
      .core_req_valid_i(core_req_valid_i[c]),
      .core_req_i(core_req_i[c]),
      .core_req_credit_o(core_req_credit_o[c]),
      .core_rsp_valid_o(core_rsp_valid_o[c]),
      .core_rsp_o(core_rsp_o[c]),
      .core_rsp_credit_i(core_rsp_credit_i[c]),
      .east_pkt_valid_i(east_pkt_valid_li[c]),
      .east_pkt_i(east_pkt_li[c]),
      .east_pkt_credit_o(east_pkt_credit_lo[c]),
      .west_pkt_valid_o(west_pkt_valid_lo[c]),
      .west_pkt_o(west_pkt_lo[c]),
      .west_pkt_credit_i(west_pkt_credit_li[c]),
      .west_fill_valid_i(west_fill_valid_li[c]),
      .west_fill_i(west_fill_li[c]),
      .west_fill_credit_o(west_fill_credit_lo[c]),
      .east_fill_valid_o(east_fill_valid_lo[c]),
      .east_fill_o(east_fill_lo[c]),
      .east_fill_credit_i(east_fill_credit_li[c])
    );

    // west edge faces memory
    if (c == 0) begin : west_edge
      assign mem_req_valid_o       = west_pkt_valid_lo[c];
      assign mem_req_o             = west_pkt_lo[c];
      assign west_pkt_credit_li[c] = mem_req_credit_i;
      assign west_fill_valid_li[c] = mem_fill_valid_i;
      assign west_fill_li[c]       = mem_fill_i;
      assign mem_fill_credit_o     = west_fill_credit_lo[c];
    end else begin : west_link
      assign east_pkt_valid_li[c-1]   = west_pkt_valid_lo[c];
      assign east_pkt_li[c-1]         = west_pkt_lo[c];
      assign west_pkt_credit_li[c]    = east_pkt_credit_lo[c-1];
      assign west_fill_valid_li[c]    = east_fill_valid_lo[c-1];
      assign west_fill_li[c]          = east_fill_lo[c-1];
      assign east_fill_credit_li[c-1] = west_fill_credit_lo[c];
    end

    // nothing lies east of the last tile
    if (c == `NUM_COLS-1) begin : east_edge
      assign east_pkt_valid_li[c]   = 1'b0;
      assign east_pkt_li[c]         = '0;
      assign east_fill_credit_li[c] = 1'b0;
    end

  end

endmodule

// ==== source/vcache_pkg.sv ====
// vcache package
// core request and response structs, memory packet struct

`include "vcache_macros.svh"

package vcache_pkg;

  typedef enum logic {
    OP_LOAD  = 1'b0,
    OP_STORE = 1'b1
  } core_op_e;

  // north side request, 45 bits
  typedef struct packed {
    core_op_e              op;
    logic [`ADDR_W-1:0]    addr;
    logic [`DATA_W-1:0]    data;
  } core_req_s;

  // store response is a bare acknowledge
  typedef struct packed {
    core_op_e              op;
    logic [`DATA_W-1:0]    data;
  } core_rsp_s;

  // west-going reads and writes, east-going fills, 47 bits
  // OP_LOAD reads, OP_STORE writes
  typedef struct packed {
    core_op_e              op;
    logic [`COL_W-1:0]     col;
    logic [`ADDR_W-1:0]    addr;
    logic [`DATA_W-1:0]    data;
  } mem_pkt_s;

endpackage

// ==== source/vcache_subarray_top.sv ====
// vcache_subarray_top: top level of the vcache row
// struct links split into plain per-field ports

`timescale 1ns/1ps
`include "vcache_macros.svh"

module vcache_subarray_top (
  input  logic                                clk_i,
  input  logic                                arst_n_i,

  input  logic [`NUM_COLS-1:0]                core_req_valid_i,
  input  logic [`NUM_COLS-1:0]                core_req_op_i,
  input  logic [`NUM_COLS-1:0][`ADDR_W-1:0]   core_req_addr_i,
  input  logic [`NUM_COLS-1:0][`DATA_W-1:0]   core_req_data_i,
  output logic [`NUM_COLS-1:0]                core_req_credit_o,
  output logic [`NUM_COLS-1:0]                core_rsp_valid_o,
  output logic [`NUM_COLS-1:0]                core_rsp_op_o,
  output logic [`NUM_COLS-1:0][`DATA_W-1:0]   core_rsp_data_o,
  input  logic [`NUM_COLS-1:0]                core_rsp_credit_i,

  output logic                                mem_req_valid_o,
  output logic                                mem_req_op_o,
  output logic [`COL_W-1:0]                   mem_req_col_o,
  output logic [`ADDR_W-1:0]                  mem_req_addr_o,
  output logic [`DATA_W-1:0]                  mem_req_data_o,
  input  logic                                mem_req_credit_i,

  input  logic                                mem_fill_valid_i,
  input  logic [`COL_W-1:0]                   mem_fill_col_i,
  input  logic [`ADDR_W-1:0]                  mem_fill_addr_i,
  input  logic [`DATA_W-1:0]                  mem_fill_data_i,
  output logic                                mem_fill_credit_o
);

  import vcache_pkg::*;

  wire core_req_s [`NUM_COLS-1:0] core_req;
  wire core_rsp_s [`NUM_COLS-1:0] core_rsp;
  wire mem_pkt_s                  mem_req;
  wire mem_pkt_s                  mem_fill;

  for (genvar c = 0; c < `NUM_COLS; c++) begin : col
    assign core_req[c] = '{op: core_op_e'(core_req_op_i[c]),
                           addr: core_req_addr_i[c],
                           data: core_req_data_i[c]};
    assign core_rsp_op_o[c]   = core_rsp[c].op;
    assign core_rsp_data_o[c] = core_rsp[c].data;
  end

  assign mem_req_op_o   = mem_req.op;
  assign mem_req_col_o  = mem_req.col;
  assign mem_req_addr_o = mem_req.addr;
  assign mem_req_data_o = mem_req.data;

  // fills always carry read data
  assign mem_fill = '{op: OP_LOAD, col: mem_fill_col_i,
                      addr: mem_fill_addr_i, data: mem_fill_data_i};

  vcache_array array (
    .clk_i(clk_i),
    .arst_n_i(arst_n_i),
    .core_req_valid_i(core_req_valid_i),
    .core_req_i(core_req),
    .core_req_credit_o(core_req_credit_o),
    .core_rsp_valid_o(core_rsp_valid_o),
    .core_rsp_o(core_rsp),
    .core_rsp_credit_i(core_rsp_credit_i),
    .mem_req_valid_o(mem_req_valid_o),
    .mem_req_o(mem_req),
    .mem_req_credit_i(mem_req_credit_i),
    .mem_fill_valid_i(mem_fill_valid_i),
    .mem_fill_i(mem_fill),
    .mem_fill_credit_o(mem_fill_credit_o)
  );

endmodule

// ==== source/vcache_tile.sv ====
// vcache_tile: one direct-mapped write-through cache column
// tag and data arrays, miss control, west and east packet forwarding

`timescale 1ns/1ps
`include "vcache_macros.svh"

module vcache_tile #(
  parameter int COL = 0
) (
  input  logic                  clk_i,
  input  logic                  arst_n_i,

  // north link
  input  logic                  core_req_valid_i,
  input  vcache_pkg::core_req_s core_req_i,
  output logic                  core_req_credit_o,
  output logic                  core_rsp_valid_o,
  output vcache_pkg::core_rsp_s core_rsp_o,
  input  logic                  core_rsp_credit_i,

  // west-going requests
  input  logic                  east_pkt_valid_i,
  input  vcache_pkg::mem_pkt_s  east_pkt_i,
  output logic                  east_pkt_credit_o,
  output logic                  west_pkt_valid_o,
  output vcache_pkg::mem_pkt_s  west_pkt_o,
  input  logic                  west_pkt_credit_i,

  // east-going fills
  input  logic                  west_fill_valid_i,
  input  vcache_pkg::mem_pkt_s  west_fill_i,
  output logic                  west_fill_credit_o,
  output logic                  east_fill_valid_o,
  output vcache_pkg::mem_pkt_s  east_fill_o,
  input  logic                  east_fill_credit_i
);

  import vcache_pkg::*;

  localparam int idx_width_lp = $clog2(`SETS);
  localparam int tag_width_lp = `ADDR_W - idx_width_lp;
  localparam int cnt_width_lp = $clog2(`FIFO_DEPTH + 1);
  localparam logic [`COL_W-1:0] my_col_lp = `COL_W'(COL);

  core_req_s               req;
  logic                    req_valid;
  logic                    req_pop;
  mem_pkt_s                thru;
  logic                    thru_valid;
  logic                    thru_pop;
  mem_pkt_s                fill;
  logic                    fill_valid;
  logic                    fill_pop;

  logic [`SETS-1:0]        line_valid_q;
  logic [tag_width_lp-1:0] tag_q  [`SETS];
  logic [`DATA_W-1:0]      data_q [`SETS];
  logic                    miss_q;

  logic [cnt_width_lp-1:0] rsp_cnt_q;
  logic [cnt_width_lp-1:0] west_cnt_q;
  logic [cnt_width_lp-1:0] east_cnt_q;
  logic                    rsp_avail;
  logic                    west_avail;
  logic                    east_avail;

  logic [idx_width_lp-1:0] req_idx;
  logic [tag_width_lp-1:0] req_tag;
  logic [idx_width_lp-1:0] fill_idx;
  logic                    hit;
  logic                    is_store;
  logic                    need_west;
  logic                    need_rsp;
  logic                    fill_own;
  logic                    fill_own_go;
  logic                    fill_fwd_go;
  logic                    own_west_go;
  logic                    west_go;
  logic                    rsp_go;

  function automatic logic [cnt_width_lp-1:0] credit_next(
    input logic [cnt_width_lp-1:0] cnt,
    input logic                    take,
    input logic                    give
  );
    credit_next = cnt - cnt_width_lp'(take) + cnt_width_lp'(give);
  endfunction

  credit_fifo #(.payload_t(core_req_s), .FIFO_DEPTH(`FIFO_DEPTH)) req_fifo (
    .clk_i(clk_i), .arst_n_i(arst_n_i),
    .valid_i(core_req_valid_i), .data_i(core_req_i),
    .valid_o(req_valid), .data_o(req),
    .pop_i(req_pop), .credit_o(core_req_credit_o)
  );

  credit_fifo #(.payload_t(mem_pkt_s), .FIFO_DEPTH(`FIFO_DEPTH)) thru_fifo (
    .clk_i(clk_i), .arst_n_i(arst_n_i),
    .valid_i(east_pkt_valid_i), .data_i(east_pkt_i),
    .valid_o(thru_valid), .data_o(thru),
    .pop_i(thru_pop), .credit_o(east_pkt_credit_o)
  );

  credit_fifo #(.payload_t(mem_pkt_s), .FIFO_DEPTH(`FIFO_DEPTH)) fill_fifo (
    .clk_i(clk_i), .arst_n_i(arst_n_i),
    .valid_i(west_fill_valid_i), .data_i(west_fill_i),
    .valid_o(fill_valid), .data_o(fill),
    .pop_i(fill_pop), .credit_o(west_fill_credit_o)
  );

  assign rsp_avail  = (rsp_cnt_q != '0);
  assign west_avail = (west_cnt_q != '0);
  assign east_avail = (east_cnt_q != '0);

  // lookup on the request FIFO head
  assign req_idx   = req.addr[idx_width_lp-1:0];
  assign req_tag   = req.addr[`ADDR_W-1:idx_width_lp];
  assign hit       = line_valid_q[req_idx] && (tag_q[req_idx] == req_tag);
  assign is_store  = (req.op == OP_STORE);
  assign need_west = is_store || !hit;
  assign need_rsp  = is_store || hit;

  // through traffic wins the west port
  assign thru_pop    = thru_valid && west_avail;
  assign req_pop     = req_valid && !miss_q
                       && (!need_west || (!thru_valid && west_avail))
                       && (!need_rsp || rsp_avail);
  assign own_west_go = req_pop && need_west;
  assign west_go     = thru_pop || own_west_go;

  assign fill_idx    = fill.addr[idx_width_lp-1:0];
  assign fill_own    = (fill.col == my_col_lp);
  assign fill_own_go = fill_valid && fill_own && miss_q && rsp_avail;
  assign fill_fwd_go = fill_valid && !fill_own && east_avail;
  assign fill_pop    = fill_own_go || fill_fwd_go;

  // miss_q keeps fill and request responses apart
  assign rsp_go = fill_own_go || (req_pop && need_rsp);

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      line_valid_q      <= '0;
      miss_q            <= 1'b0;
      rsp_cnt_q         <= cnt_width_lp'(`FIFO_DEPTH);
      west_cnt_q        <= cnt_width_lp'(`FIFO_DEPTH);
      east_cnt_q        <= cnt_width_lp'(`FIFO_DEPTH);
      core_rsp_valid_o  <= 1'b0;
      west_pkt_valid_o  <= 1'b0;
      east_fill_valid_o <= 1'b0;
    end else begin
      if (fill_own_go) begin
        line_valid_q[fill_idx] <= 1'b1;
        miss_q                 <= 1'b0;
      end else if (req_pop && !is_store && !hit) begin
        miss_q <= 1'b1;
      end
      rsp_cnt_q         <= credit_next(rsp_cnt_q, rsp_go, core_rsp_credit_i);
      west_cnt_q        <= credit_next(west_cnt_q, west_go, west_pkt_credit_i);
      east_cnt_q        <= credit_next(east_cnt_q, fill_fwd_go, east_fill_credit_i);
      core_rsp_valid_o  <= rsp_go;
      west_pkt_valid_o  <= west_go;
      east_fill_valid_o <= fill_fwd_go;
    end
  end

  // line update, no write allocate on store miss
  always_ff @(posedge clk_i) begin
    if (fill_own_go) begin
      tag_q[fill_idx]  <= fill.addr[`ADDR_W-1:idx_width_lp];
      data_q[fill_idx] <= fill.data;
    end else if (req_pop && is_store && hit) begin
      data_q[req_idx] <= req.data;
    end
  end

  always_ff @(posedge clk_i) begin
    if (rsp_go) begin
      if (fill_own_go) begin
        core_rsp_o <= '{op: OP_LOAD, data: fill.data};
      end else if (is_store) begin
        core_rsp_o <= '{op: OP_STORE, data: '0};
      end else begin
        core_rsp_o <= '{op: OP_LOAD, data: data_q[req_idx]};
      end
    end
    if (thru_pop) begin
      west_pkt_o <= thru;
    end else if (own_west_go) begin
      // write-through or miss read
      west_pkt_o <= '{op: req.op, col: my_col_lp, addr: req.addr,
                      data: is_store ? req.data : '0};
    end
    if (fill_fwd_go) begin
      east_fill_o <= fill;
    end
  end

endmodule

// ==== tests/tb_clock_gen.sv ====
// testbench clock and reset source
// 20 ns clock, reset held low for a few cycles

`timescale 1ns/1ps

module tb_clock_gen #(
  parameter int RESET_CYCLES = 5
) (
  output logic clk_o,
  output logic arst_n_o
);

  initial begin
    clk_o = 1'b0;
    forever #10 clk_o = ~clk_o;
  end

  initial begin
    arst_n_o = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk_o);
    arst_n_o <= 1'b1;
  end

endmodule

// ==== tests/tb_vcache_subarray.sv ====
// vcache subarray testbench
// directed and random traffic per column, memory model at the west edge
// shadow memory, program-order reference and response checks

`timescale 1ns/1ps
`include "vcache_macros.svh"

module tb_vcache_subarray;

  import vcache_pkg::*;

  localparam int depth_lp   = `FIFO_DEPTH;
  localparam int ring_lp    = 16;
  localparam int words_lp   = 1 << `ADDR_W;
  localparam int timeout_lp = 2000;

  logic                              clk_i;
  logic                              arst_n_i;
  logic [`NUM_COLS-1:0]              core_req_valid_i;
  logic [`NUM_COLS-1:0]              core_req_op_i;
  logic [`NUM_COLS-1:0][`ADDR_W-1:0] core_req_addr_i;
  logic [`NUM_COLS-1:0][`DATA_W-1:0] core_req_data_i;
  logic [`NUM_COLS-1:0]              core_req_credit_o;
  logic [`NUM_COLS-1:0]              core_rsp_valid_o;
  logic [`NUM_COLS-1:0]              core_rsp_op_o;
  logic [`NUM_COLS-1:0][`DATA_W-1:0] core_rsp_data_o;
  logic [`NUM_COLS-1:0]              core_rsp_credit_i;
  logic                              mem_req_valid_o;
  logic                              mem_req_op_o;
  logic [`COL_W-1:0]                 mem_req_col_o;
  logic [`ADDR_W-1:0]                mem_req_addr_o;
  logic [`DATA_W-1:0]                mem_req_data_o;
  logic                              mem_req_credit_i;
  logic                              mem_fill_valid_i;
  logic [`COL_W-1:0]                 mem_fill_col_i;
  logic [`ADDR_W-1:0]                mem_fill_addr_i;
  logic [`DATA_W-1:0]                mem_fill_data_i;
  logic                              mem_fill_credit_o;

  logic [31:0]        rng_state;
  logic [`DATA_W-1:0] shadow_mem [words_lp];
  logic [`DATA_W-1:0] ref_mem    [words_lp];
  logic               exp_op     [`NUM_COLS][ring_lp];
  logic [`DATA_W-1:0] exp_data   [`NUM_COLS][ring_lp];
  int                 exp_head   [`NUM_COLS];
  int                 exp_tail   [`NUM_COLS];
  int                 req_credits[`NUM_COLS];
  int                 rsp_owed   [`NUM_COLS];
  int                 fill_credits;
  int                 mem_reads;
  int                 mem_writes;
  int                 stores_sent;
  logic               mem_hold;
  logic               rsp_hold;
  mem_pkt_s           last_mem_pkt;
  mem_pkt_s           mem_rx_q [$];
  mem_pkt_s           fill_tx_q [$];

  tb_clock_gen clock_gen (
    .clk_o(clk_i),
    .arst_n_o(arst_n_i)
  );

  vcache_subarray_top dut (
    .clk_i(clk_i),
    .arst_n_i(arst_n_i),
    .core_req_valid_i(core_req_valid_i),
    .core_req_op_i(core_req_op_i),
    .core_req_addr_i(core_req_addr_i),
    .core_req_data_i(core_req_data_i),
    .core_req_credit_o(core_req_credit_o),
    .core_rsp_valid_o(core_rsp_valid_o),
    .core_rsp_op_o(core_rsp_op_o),
    .core_rsp_data_o(core_rsp_data_o),
    .core_rsp_credit_i(core_rsp_credit_i),
    .mem_req_valid_o(mem_req_valid_o),
    .mem_req_op_o(mem_req_op_o),
    .mem_req_col_o(mem_req_col_o),
    .mem_req_addr_o(mem_req_addr_o),
    .mem_req_data_o(mem_req_data_o),
    .mem_req_credit_i(mem_req_credit_i),
    .mem_fill_valid_i(mem_fill_valid_i),
    .mem_fill_col_i(mem_fill_col_i),
    .mem_fill_addr_i(mem_fill_addr_i),
    .mem_fill_data_i(mem_fill_data_i),
    .mem_fill_credit_o(mem_fill_credit_o)
  );

  // unwritten words of the memory
  function automatic logic [`DATA_W-1:0] default_word(input logic [`ADDR_W-1:0] addr);
    default_word = {{(`DATA_W - `ADDR_W){1'b0}}, addr} ^ 32'hA5A5_0000;
  endfunction

  function automatic logic [31:0] next_rand();
    rng_state = rng_state * 32'd1664525 + 32'd1013904223;
    next_rand = rng_state ^ (rng_state >> 16);
  endfunction

  function automatic logic all_idle();
    all_idle = (mem_rx_q.size() == 0) && (fill_tx_q.size() == 0)
               && (mem_writes == stores_sent);
    for (int c = 0; c < `NUM_COLS; c++) begin
      if (exp_head[c] != exp_tail[c] || rsp_owed[c] != 0) begin
        all_idle = 1'b0;
      end
    end
  endfunction

  task automatic fail_run(input string msg);
    $display("%s", msg);
    $display("Result: FAILED");
    $fatal(1);
  endtask

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    assert (got === exp) else begin
      fail_run($sformatf("** Error: %s = %h, expected %h", name, got, exp));
    end
  endtask

  task automatic check_true(input logic cond, input string what);
    assert (cond) else begin
      fail_run($sformatf("** Error: %s", what));
    end
  endtask

  // sample outputs at the falling edge then play north side and memory
  task automatic step();
    mem_pkt_s pkt;
    int       slot;
    @(negedge clk_i);
    core_req_valid_i  = '0;
    core_rsp_credit_i = '0;
    mem_req_credit_i  = 1'b0;
    mem_fill_valid_i  = 1'b0;
    for (int c = 0; c < `NUM_COLS; c++) begin
      if (core_req_credit_o[c]) begin
        req_credits[c]++;
      end
      if (core_rsp_valid_o[c]) begin
        check_true(exp_head[c] != exp_tail[c], $sformatf("response on idle column %0d", c));
        slot = exp_head[c] % ring_lp;
        check_value($sformatf("core_rsp_op_o[%0d]", c), 32'(core_rsp_op_o[c]),
                    32'(exp_op[c][slot]));
        if (exp_op[c][slot] == OP_LOAD) begin
          check_value($sformatf("core_rsp_data_o[%0d]", c), core_rsp_data_o[c],
                      exp_data[c][slot]);
        end
        exp_head[c]++;
        rsp_owed[c]++;
      end
      check_true(req_credits[c] >= 0 && req_credits[c] <= depth_lp,
                 $sformatf("request credits out of range on column %0d", c));
      check_true(rsp_owed[c] <= depth_lp,
                 $sformatf("more responses than credits on column %0d", c));
    end
    if (mem_fill_credit_o) begin
      fill_credits++;
    end
    check_true(fill_credits >= 0 && fill_credits <= depth_lp, "fill credits out of range");
    if (mem_req_valid_o) begin
      pkt = '{op: core_op_e'(mem_req_op_o), col: mem_req_col_o,
              addr: mem_req_addr_o, data: mem_req_data_o};
      check_value("mem_req_col_o", 32'(mem_req_col_o),
                  32'(mem_req_addr_o[`ADDR_W-1 -: `COL_W]));
      mem_rx_q.push_back(pkt);
      last_mem_pkt = pkt;
      if (pkt.op == OP_STORE) begin
        mem_writes++;
      end else begin
        mem_reads++;
      end
      check_true(mem_rx_q.size() <= depth_lp, "memory request sent without a credit");
    end
    for (int c = 0; c < `NUM_COLS; c++) begin
      if (rsp_owed[c] > 0 && !rsp_hold) begin
        core_rsp_credit_i[c] = 1'b1;
        rsp_owed[c]--;
      end
    end
    // memory takes one packet per cycle unless holding
    if (mem_rx_q.size() > 0 && !mem_hold) begin
      pkt = mem_rx_q.pop_front();
      mem_req_credit_i = 1'b1;
      if (pkt.op == OP_STORE) begin
        shadow_mem[pkt.addr] = pkt.data;
      end else begin
        pkt.data = shadow_mem[pkt.addr];
        fill_tx_q.push_back(pkt);
      end
    end
    if (fill_tx_q.size() > 0 && fill_credits > 0) begin
      pkt = fill_tx_q.pop_front();
      mem_fill_valid_i = 1'b1;
      mem_fill_col_i   = pkt.col;
      mem_fill_addr_i  = pkt.addr;
      mem_fill_data_i  = pkt.data;
      fill_credits--;
    end
  endtask

  task automatic issue(input int col, input logic op, input logic [`ADDR_W-1:0] addr,
                       input logic [`DATA_W-1:0] data);
    int slot;
    check_true(req_credits[col] > 0, "request issued without a credit");
    slot = exp_tail[col] % ring_lp;
    core_req_valid_i[col] = 1'b1;
    core_req_op_i[col]    = op;
    core_req_addr_i[col]  = addr;
    core_req_data_i[col]  = data;
    req_credits[col]--;
    exp_op[col][slot]   = op;
    exp_data[col][slot] = (op == OP_STORE) ? '0 : ref_mem[addr];
    if (op == OP_STORE) begin
      ref_mem[addr] = data;
      stores_sent++;
    end
    exp_tail[col]++;
  endtask

  task automatic wait_idle(input string what);
    int cycles;
    cycles = 0;
    while (!all_idle()) begin
      step();
      cycles++;
      if (cycles > timeout_lp) begin
        fail_run($sformatf("** Error: timed out waiting for %s", what));
      end
    end
  endtask

  task automatic wait_reset();
    int cycles;
    cycles = 0;
    step();
    while (!arst_n_i) begin
      step();
      cycles++;
      if (cycles > 50) begin
        fail_run("** Error: reset was never released");
      end
    end
  endtask

  initial begin
    logic [`ADDR_W-1:0] addr_a;
    logic [`ADDR_W-1:0] addr_b;
    logic [`ADDR_W-1:0] addr;
    logic [31:0]        r;
    int                 reads0;
    int                 writes0;
    core_req_valid_i  = '0;
    core_req_op_i     = '0;
    core_req_addr_i   = '0;
    core_req_data_i   = '0;
    core_rsp_credit_i = '0;
    mem_req_credit_i  = 1'b0;
    mem_fill_valid_i  = 1'b0;
    mem_fill_col_i    = '0;
    mem_fill_addr_i   = '0;
    mem_fill_data_i   = '0;
    rng_state    = 32'h4e5e;
    fill_credits = depth_lp;
    mem_reads    = 0;
    mem_writes   = 0;
    stores_sent  = 0;
    mem_hold     = 1'b0;
    rsp_hold     = 1'b0;
    for (int c = 0; c < `NUM_COLS; c++) begin
      exp_head[c]    = 0;
      exp_tail[c]    = 0;
      req_credits[c] = depth_lp;
      rsp_owed[c]    = 0;
    end
    for (int a = 0; a < words_lp; a++) begin
      shadow_mem[a] = default_word(`ADDR_W'(a));
      ref_mem[a]    = default_word(`ADDR_W'(a));
    end
    wait_reset();

    // quiet outputs before any stimulus
    for (int i = 0; i < 5; i++) begin
      step();
      check_value("core_rsp_valid_o", 32'(core_rsp_valid_o), 32'h0);
      check_value("core_req_credit_o", 32'(core_req_credit_o), 32'h0);
      check_value("mem_req_valid_o", 32'(mem_req_valid_o), 32'h0);
      check_value("mem_fill_credit_o", 32'(mem_fill_credit_o), 32'h0);
    end

    // cold miss and then a hit on the same word
    addr_a  = {`COL_W'(1), 10'h021};
    reads0  = mem_reads;
    writes0 = mem_writes;
    issue(1, OP_LOAD, addr_a, '0);
    wait_idle("the cold load on column 1");
    check_value("memory reads", 32'(mem_reads - reads0), 32'd1);
    check_value("memory writes", 32'(mem_writes - writes0), 32'd0);
    check_value("mem_req_col_o", 32'(last_mem_pkt.col), 32'd1);
    check_value("mem_req_addr_o", 32'(last_mem_pkt.addr), 32'(addr_a));
    reads0 = mem_reads;
    issue(1, OP_LOAD, addr_a, '0);
    wait_idle("the repeated load on column 1");
    check_value("memory reads", 32'(mem_reads - reads0), 32'd0);
    check_value("memory writes", 32'(mem_writes - writes0), 32'd0);

    // store miss goes through and the load after it misses
    addr_b  = {`COL_W'(2), 10'h0d5};
    writes0 = mem_writes;
    issue(2, OP_STORE, addr_b, 32'h5a17_3c96);
    wait_idle("the store on column 2");
    check_value("memory writes", 32'(mem_writes - writes0), 32'd1);
    check_value("mem_req_op_o", 32'(last_mem_pkt.op), 32'(OP_STORE));
    check_value("mem_req_col_o", 32'(last_mem_pkt.col), 32'd2);
    check_value("mem_req_addr_o", 32'(last_mem_pkt.addr), 32'(addr_b));
    check_value("mem_req_data_o", last_mem_pkt.data, 32'h5a17_3c96);
    issue(2, OP_LOAD, addr_b, '0);
    wait_idle("the load after the store on column 2");

    // store hit updates the line and the load after it hits
    writes0 = mem_writes;
    issue(1, OP_STORE, addr_a, 32'h0bad_f00d);
    wait_idle("the store hit on column 1");
    check_value("memory writes", 32'(mem_writes - writes0), 32'd1);
    check_value("mem_req_data_o", last_mem_pkt.data, 32'h0bad_f00d);
    reads0 = mem_reads;
    issue(1, OP_LOAD, addr_a, '0);
    wait_idle("the load after the store hit on column 1");
    check_value("memory reads", 32'(mem_reads - reads0), 32'd0);

    // random traffic with back-pressure from memory and north side
    for (int n = 0; n < 800; n++) begin
      step();
      r = next_rand();
      mem_hold = (r[3:0] < 4'd5);
      rsp_hold = (r[7:4] < 4'd2);
      for (int c = 0; c < `NUM_COLS; c++) begin
        r = next_rand();
        if (req_credits[c] > 0 && r[0]) begin
          // sixteen words per column and two per set
          addr = {`COL_W'(c), 6'h00, r[11:8]};
          issue(c, r[1], addr, next_rand());
        end
      end
    end
    mem_hold = 1'b0;
    rsp_hold = 1'b0;
    wait_idle("random traffic to drain");
    for (int a = 0; a < words_lp; a++) begin
      check_value($sformatf("shadow_mem[%h]", a), shadow_mem[a], ref_mem[a]);
    end

    $display("Result: PASSED");
    $finish;
  end

endmodule
